// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = tb_instr_fetch
FILELIST = build.f
PASS     = PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS)"

clean:
	rm -rf obj_dir

// File: build.f
+incdir+hw
hw/fetch_pkg.sv
hw/predict_if.sv
hw/pc_generator.sv
hw/branch_predictor.sv
hw/instr_queue.sv
hw/fetch_control.sv
hw/instr_fetch.sv
sim/tb_instr_fetch.sv

// File: hw/branch_predictor.sv
`include "fetch_params.svh"

module branch_predictor (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  logic                                        flush,
	input  logic                                        hold,
	input  fetch_pkg::virt_t                            group_pc,
	input  logic [`FETCH_NUM-1:0][31:0]                 instr,
	input  logic [`FETCH_NUM-1:0]                       slot_valid,
	input  fetch_pkg::branch_resolved_t                 resolved,
	predict_if.source                                   pred,
	output fetch_pkg::branch_predict_t [`FETCH_NUM-1:0] predict_out
);

import fetch_pkg::*;

localparam int FW = $clog2(`FETCH_NUM);
localparam int AW = FW + 2;
localparam int IW = $clog2(`BTB_ENTRIES);
localparam int TW = 32 - IW - 2;

// btb storage
logic [`BTB_ENTRIES-1:0] btb_valid;
logic [TW-1:0]           btb_tag    [`BTB_ENTRIES];
virt_t                   btb_target [`BTB_ENTRIES];
logic [1:0]              btb_cnt    [`BTB_ENTRIES];

cf_kind_t              slot_cf     [`FETCH_NUM];
virt_t                 slot_target [`FETCH_NUM];
logic [`FETCH_NUM-1:0] slot_taken;
logic [`FETCH_NUM-1:0] first_taken;
logic                  found;
virt_t                 sel_target;

logic [IW-1:0] upd_idx;
logic          upd_en;
logic          upd_hit;

function automatic cf_kind_t decode_cf(input logic [31:0] word);
	cf_kind_t kind;
	case (word[31:26])
		6'b000100, 6'b000101: kind = cf_branch;
		6'b000010: kind = cf_jump;
		6'b000011: kind = cf_call;
		6'b000000: kind = (word[5:0] == 6'b001000) ? cf_indirect : cf_none;
		default: kind = cf_none;
	endcase
	return kind;
endfunction

// per-slot decode and btb lookup
always_comb begin
	virt_t         spc;
	virt_t         spc4;
	logic [IW-1:0] idx;
	logic          hit;
	for (int i = 0; i < `FETCH_NUM; i++) begin
		spc = {group_pc[31:AW], FW'(i), 2'b00};
		spc4 = spc + 32'd4;
		idx = spc[IW+1:2];
		hit = btb_valid[idx] && (btb_tag[idx] == spc[31:IW+2]);
		slot_cf[i] = slot_valid[i] ? decode_cf(instr[i]) : cf_none;
		case (slot_cf[i])
			cf_branch: begin
				slot_taken[i] = hit & btb_cnt[idx][1];
				slot_target[i] = hit ? btb_target[idx] : '0;
			end
			cf_jump, cf_call: begin
				// region of the delay slot, as in MIPS
				slot_taken[i] = 1'b1;
				slot_target[i] = {spc4[31:28], instr[i][25:0], 2'b00};
			end
			default: begin
				slot_taken[i] = 1'b0;
				slot_target[i] = '0;
			end
		endcase
	end
end

// oldest taken slot wins
always_comb begin
	found = 1'b0;
	first_taken = '0;
	sel_target = '0;
	for (int i = 0; i < `FETCH_NUM; i++) begin
		if (slot_taken[i] && !found) begin
			found = 1'b1;
			first_taken[i] = 1'b1;
			sel_target = slot_target[i];
		end
	end
end

assign pred.valid = found & ~hold;
assign pred.delayed = pred.valid & first_taken[`FETCH_NUM-1];
assign pred.vaddr = sel_target;
assign pred.maybe_jump = first_taken;

for (genvar i = 0; i < `FETCH_NUM; i++) begin : gen_predict_out
	assign predict_out[i].cf = slot_cf[i];
	assign predict_out[i].taken = first_taken[i];
	assign predict_out[i].target = slot_target[i];
end

// training from the back end
assign upd_idx = resolved.pc[IW+1:2];
assign upd_en = resolved.valid && (resolved.cf == cf_branch);
assign upd_hit = btb_valid[upd_idx] && (btb_tag[upd_idx] == resolved.pc[31:IW+2]);

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		btb_valid <= '0;
	end else if (flush) begin
		btb_valid <= '0;
	end else if (upd_en && !upd_hit && resolved.taken) begin
		btb_valid[upd_idx] <= 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (upd_en && upd_hit) begin
		if (resolved.taken) begin
			btb_target[upd_idx] <= resolved.target;
			if (btb_cnt[upd_idx] != 2'b11) begin
				btb_cnt[upd_idx] <= btb_cnt[upd_idx] + 2'b01;
			end
		end else if (btb_cnt[upd_idx] != 2'b00) begin
			btb_cnt[upd_idx] <= btb_cnt[upd_idx] - 2'b01;
		end
	end else if (upd_en && resolved.taken) begin
		// new entry starts weakly taken
		btb_tag[upd_idx] <= resolved.pc[31:IW+2];
		btb_target[upd_idx] <= resolved.target;
		btb_cnt[upd_idx] <= 2'b10;
	end
end

endmodule

// File: hw/fetch_control.sv
`include "fetch_params.svh"

module fetch_control (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        stall,
	input  logic                        flush_pc,
	input  logic                        except_valid,
	input  fetch_pkg::branch_resolved_t resolved,
	input  fetch_pkg::virt_t            pc,
	predict_if.sink                     pred,
	input  logic                        queue_full,
	output fetch_pkg::virt_t            icache_vaddr,
	output logic                        icache_flush,
	output logic                        hold,
	output fetch_pkg::virt_t            group_pc,
	output logic [`FETCH_NUM-1:0]       slot_valid,
	output logic [`FETCH_NUM-1:0]       push_valid
);

import fetch_pkg::*;

localparam int    FW          = $clog2(`FETCH_NUM);
localparam int    AW          = FW + 2;
localparam virt_t GROUP_BYTES = virt_t'(`FETCH_NUM * 4);

ftc_state_t    state;
ftc_state_t    state_next;
virt_t         fetch_vaddr;
virt_t         fetch_vaddr_d;
virt_t         ds_vaddr;
logic [FW-1:0] offset;
logic          kill_d;
logic          redirect;

assign redirect = flush_pc | except_valid | (resolved.valid & resolved.mispredict);
assign icache_flush = redirect;
assign hold = stall | queue_full;

// stage 2 group and the address of the slot after it
assign group_pc = {fetch_vaddr_d[31:AW], {AW{1'b0}}};
assign offset = fetch_vaddr_d[AW-1:2];
assign ds_vaddr = group_pc + GROUP_BYTES;

always_comb begin
	if (hold) begin
		// re-send so the next response matches the held group
		fetch_vaddr = fetch_vaddr_d;
	end else if (pred.valid) begin
		fetch_vaddr = pred.delayed ? ds_vaddr : pred.vaddr;
	end else begin
		fetch_vaddr = pc;
	end
end

assign icache_vaddr = {fetch_vaddr[31:AW], {AW{1'b0}}};
assign state_next = (pred.valid && pred.delayed) ? fs_delayslot : fs_run;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		fetch_vaddr_d <= `BOOT_VEC;
		state <= fs_run;
		kill_d <= 1'b1;
	end else begin
		if (!hold) begin
			fetch_vaddr_d <= fetch_vaddr;
		end
		// response to the redirect-cycle request is dropped
		if (redirect) begin
			state <= fs_run;
			kill_d <= 1'b1;
		end else if (!hold) begin
			state <= state_next;
			kill_d <= 1'b0;
		end
	end
end

always_comb begin
	logic cut;
	logic arm;
	cut = 1'b0;
	arm = 1'b0;
	for (int i = 0; i < `FETCH_NUM; i++) begin
		if (kill_d) begin
			slot_valid[i] = 1'b0;
		end else if (state == fs_delayslot) begin
			slot_valid[i] = (FW'(i) == offset);
		end else begin
			slot_valid[i] = (FW'(i) >= offset);
		end
		// keep the taken slot and its delay slot, drop the rest
		push_valid[i] = slot_valid[i] & ~cut;
		cut = cut | arm;
		arm = pred.valid & pred.maybe_jump[i];
	end
end

endmodule

// File: hw/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// instructions per fetch group, a power of two
`define FETCH_NUM 2

// program counter after reset
`define BOOT_VEC 32'hbfc0_0000

// direct mapped branch target buffer
`define BTB_ENTRIES 8

// fetch queue entries, a power of two
`define IQ_DEPTH 8

// first address above the fetchable region
`define IMEM_LIMIT 32'hbfc1_0000

`endif

// File: hw/fetch_pkg.sv
package fetch_pkg;

typedef logic [31:0] virt_t;

// control flow class of one instruction
typedef enum logic [2:0] {
	cf_none,
	cf_branch,
	cf_jump,
	cf_call,
	cf_indirect
} cf_kind_t;

// per-slot prediction, travels with the entry to decode
typedef struct packed {
	cf_kind_t cf;
	logic     taken;
	virt_t    target;
} branch_predict_t;

typedef struct packed {
	logic [31:0]     instr;
	virt_t           vaddr;
	logic            addr_ex;
	branch_predict_t predict;
} fetch_entry_t;

// branch outcome reported by the back end
typedef struct packed {
	logic     valid;
	logic     mispredict;
	logic     taken;
	virt_t    pc;
	virt_t    target;
	cf_kind_t cf;
} branch_resolved_t;

// fs_delayslot while stage 2 holds a lone delay-slot fetch
typedef enum logic {
	fs_run,
	fs_delayslot
} ftc_state_t;

endpackage

// File: hw/instr_fetch.sv
`include "fetch_params.svh"

module instr_fetch (
	input  logic                                     clk,
	input  logic                                     rst_n,
	// instruction cache
	output fetch_pkg::virt_t                         icache_vaddr,
	output logic                                     icache_flush,
	input  logic [`FETCH_NUM-1:0][31:0]              icache_data,
	input  logic                                     icache_addr_ex,
	// back end
	input  logic                                     flush_pc,
	input  logic                                     flush_bp,
	input  logic                                     stall,
	input  logic                                     except_valid,
	input  fetch_pkg::virt_t                         except_vec,
	input  fetch_pkg::branch_resolved_t              resolved_branch,
	// decode
	output fetch_pkg::fetch_entry_t [`FETCH_NUM-1:0] fetch_entry,
	output logic [`FETCH_NUM-1:0]                    fetch_valid,
	input  logic [$clog2(`FETCH_NUM+1)-1:0]          fetch_ack
);

import fetch_pkg::*;

localparam int FW = $clog2(`FETCH_NUM);
localparam int AW = FW + 2;

virt_t                            pc;
virt_t                            group_pc;
logic                             hold;
logic                             queue_full;
logic [`FETCH_NUM-1:0]            slot_valid;
logic [`FETCH_NUM-1:0]            push_valid;
branch_predict_t [`FETCH_NUM-1:0] predict_out;
fetch_entry_t [`FETCH_NUM-1:0]    push_entry;

predict_if pred_bus ();

// slot address is the group base with the slot index
for (genvar i = 0; i < `FETCH_NUM; i++) begin : gen_push_entry
	assign push_entry[i].instr = icache_data[i];
	assign push_entry[i].vaddr = {group_pc[31:AW], FW'(i), 2'b00};
	assign push_entry[i].addr_ex = icache_addr_ex;
	assign push_entry[i].predict = predict_out[i];
end

fetch_control ctrl0 (
	.clk, .rst_n, .stall, .flush_pc, .except_valid,
	.resolved (resolved_branch), .pc, .pred (pred_bus.sink), .queue_full,
	.icache_vaddr, .icache_flush, .hold, .group_pc, .slot_valid, .push_valid
);

pc_generator pcg0 (
	.clk, .rst_n, .hold, .except_valid, .except_vec,
	.resolved (resolved_branch), .pred (pred_bus.sink), .pc
);

branch_predictor bp0 (
	.clk, .rst_n, .flush (flush_bp), .hold, .group_pc, .instr (icache_data),
	.slot_valid, .resolved (resolved_branch), .pred (pred_bus.source), .predict_out
);

instr_queue iq0 (
	.clk, .rst_n, .flush (icache_flush), .hold, .push_valid, .push_entry,
	.full (queue_full), .fetch_ack, .fetch_entry, .fetch_valid
);

endmodule

// File: hw/instr_queue.sv
`include "fetch_params.svh"

module instr_queue (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  logic                                     flush,
	input  logic                                     hold,
	input  logic [`FETCH_NUM-1:0]                    push_valid,
	input  fetch_pkg::fetch_entry_t [`FETCH_NUM-1:0] push_entry,
	output logic                                     full,
	input  logic [$clog2(`FETCH_NUM+1)-1:0]          fetch_ack,
	output fetch_pkg::fetch_entry_t [`FETCH_NUM-1:0] fetch_entry,
	output logic [`FETCH_NUM-1:0]                    fetch_valid
);

import fetch_pkg::*;

localparam int PW = $clog2(`IQ_DEPTH);
localparam int CW = $clog2(`IQ_DEPTH + 1);
localparam int NW = $clog2(`FETCH_NUM + 1);

fetch_entry_t  mem [`IQ_DEPTH];
logic [PW-1:0] rd_ptr;
logic [PW-1:0] wr_ptr;
logic [CW-1:0] count;

logic [NW-1:0] push_num;
logic [PW-1:0] slot_pos [`FETCH_NUM];
logic          do_push;

// compact valid slots onto consecutive places from wr_ptr
always_comb begin
	push_num = '0;
	for (int i = 0; i < `FETCH_NUM; i++) begin
		slot_pos[i] = wr_ptr + PW'(push_num);
		push_num = push_num + NW'(push_valid[i]);
	end
end

assign do_push = ~hold & ~flush;

always_ff @(posedge clk) begin
	if (do_push) begin
		for (int i = 0; i < `FETCH_NUM; i++) begin
			if (push_valid[i]) begin
				mem[slot_pos[i]] <= push_entry[i];
			end
		end
	end
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		rd_ptr <= '0;
		wr_ptr <= '0;
		count <= '0;
	end else if (flush) begin
		rd_ptr <= '0;
		wr_ptr <= '0;
		count <= '0;
	end else begin
		// decode never acks more than is presented
		rd_ptr <= rd_ptr + PW'(fetch_ack);
		if (do_push) begin
			wr_ptr <= wr_ptr + PW'(push_num);
			count <= count + CW'(push_num) - CW'(fetch_ack);
		end else begin
			count <= count - CW'(fetch_ack);
		end
	end
end

// oldest entries first, valid bits contiguous from slot 0
always_comb begin
	for (int i = 0; i < `FETCH_NUM; i++) begin
		fetch_entry[i] = mem[rd_ptr + PW'(i)];
		fetch_valid[i] = (CW'(i) < count);
	end
end

// room for a whole group is required
assign full = (count > CW'(`IQ_DEPTH - `FETCH_NUM));

endmodule

// File: hw/pc_generator.sv
`include "fetch_params.svh"

module pc_generator (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        hold,
	input  logic                        except_valid,
	input  fetch_pkg::virt_t            except_vec,
	input  fetch_pkg::branch_resolved_t resolved,
	predict_if.sink                     pred,
	output fetch_pkg::virt_t            pc
);

import fetch_pkg::*;

localparam int    AW          = $clog2(`FETCH_NUM) + 2;
localparam virt_t GROUP_BYTES = virt_t'(`FETCH_NUM * 4);

logic mispredict;

// start of the group after the one holding addr
function automatic virt_t next_group(input virt_t addr);
	return {addr[31:AW], {AW{1'b0}}} + GROUP_BYTES;
endfunction

assign mispredict = resolved.valid & resolved.mispredict;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		pc <= `BOOT_VEC;
	end else if (except_valid) begin
		pc <= except_vec;
	end else if (mispredict) begin
		// not taken resumes after the branch and its delay slot
		if (resolved.taken) begin
			pc <= resolved.target;
		end else begin
			pc <= resolved.pc + 32'd8;
		end
	end else if (pred.valid && !pred.delayed) begin
		// target is being fetched this cycle
		pc <= next_group(pred.vaddr);
	end else if (!hold) begin
		if (pred.valid) begin
			// delay slot goes out now, target on the next cycle
			pc <= pred.vaddr;
		end else begin
			pc <= next_group(pc);
		end
	end
end

endmodule

// File: hw/predict_if.sv
`include "fetch_params.svh"

interface predict_if;

import fetch_pkg::*;

// valid only for the group currently in stage 2
logic                  valid;
// predicted branch sits in the last slot
logic                  delayed;
virt_t                 vaddr;
// one-hot, the slot that was predicted taken
logic [`FETCH_NUM-1:0] maybe_jump;

modport source (output valid, output delayed, output vaddr, output maybe_jump);

modport sink (input valid, input delayed, input vaddr, input maybe_jump);

endinterface

// File: sim/tb_instr_fetch.sv
`include "fetch_params.svh"

module tb_instr_fetch;

timeunit 1ns;
timeprecision 100ps;

import fetch_pkg::*;

localparam int    NW           = $clog2(`FETCH_NUM + 1);
// planted branch sits in the last slot of its group
localparam virt_t LEARN_PC     = `BOOT_VEC + 32'h2000 + 32'(4 * (`FETCH_NUM - 1));
localparam virt_t LEARN_TARGET = `BOOT_VEC + 32'h3010;

logic                          clk;
logic                          rst_n;
virt_t                         icache_vaddr;
logic                          icache_flush;
logic [`FETCH_NUM-1:0][31:0]   icache_data = '0;
logic                          icache_addr_ex = 1'b0;
logic                          flush_pc;
logic                          flush_bp;
logic                          stall;
logic                          except_valid;
virt_t                         except_vec;
branch_resolved_t              resolved_branch;
fetch_entry_t [`FETCH_NUM-1:0] fetch_entry;
logic [`FETCH_NUM-1:0]         fetch_valid;
logic [NW-1:0]                 fetch_ack;

// scoreboard state
virt_t exp_pc;
int    ack_cur;
int    popped;
int    branch_pops;
int    fault_pops;
bit    flushing;
bit    shake;
bit    learned;
bit    in_delay_slot;

instr_fetch dut0 (.*);

initial begin
	clk = 1'b0;
	forever #10 clk = ~clk;
end

// address rotated into an addiu, except the planted beq
function automatic logic [31:0] word(input virt_t a);
	virt_t rot;
	rot = {a[1:0], a[31:2]};
	if (a == LEARN_PC) begin
		return {6'b000100, 5'd1, 5'd2, 16'h0010};
	end
	return {6'b001001, rot[25:0]};
endfunction

// one-cycle instruction memory
always @(posedge clk) begin
	for (int i = 0; i < `FETCH_NUM; i++) begin
		icache_data[i] <= word(icache_vaddr + virt_t'(4 * i));
	end
	icache_addr_ex <= (icache_vaddr >= `IMEM_LIMIT);
end

task automatic stop_on_error(input string line);
	$display("%s", line);
	$display("FAIL: see errors above");
	$fatal(1, "simulation stopped at the first error");
endtask

task automatic mismatch(input string msg);
	stop_on_error($sformatf("FAILED at %0t: %s", $time, msg));
endtask

// valid slots are contiguous from slot 0
assert property (@(posedge clk) disable iff (!rst_n)
	((32'(fetch_valid) + 32'd1) & 32'(fetch_valid)) == 32'd0)
	else mismatch("fetch_valid is not contiguous");

// a redirect leaves nothing to present in the next cycle
assert property (@(posedge clk) disable iff (!rst_n) icache_flush |=> fetch_valid == '0)
	else mismatch("entries presented right after a flush");

assert property (@(posedge clk) disable iff (!rst_n) except_valid |-> icache_flush)
	else mismatch("exception did not raise icache_flush");

task automatic check_pop(input fetch_entry_t e);
	assert (e.vaddr == exp_pc)
		else mismatch($sformatf("vaddr %h, expected %h", e.vaddr, exp_pc));
	assert (e.instr == word(e.vaddr))
		else mismatch($sformatf("instr %h at %h, expected %h", e.instr, e.vaddr, word(e.vaddr)));
	assert (e.addr_ex == (e.vaddr >= `IMEM_LIMIT))
		else mismatch($sformatf("addr_ex %b at %h", e.addr_ex, e.vaddr));
	if (learned && e.vaddr == LEARN_PC) begin
		assert (e.predict.cf == cf_branch && e.predict.taken
			&& e.predict.target == LEARN_TARGET)
			else mismatch($sformatf("learned branch at %h not predicted taken", e.vaddr));
		branch_pops++;
		in_delay_slot = 1'b1;
		exp_pc = e.vaddr + 32'd4;
	end else begin
		assert (!e.predict.taken)
			else mismatch($sformatf("unexpected taken prediction at %h", e.vaddr));
		// after the delay slot comes the target
		exp_pc = in_delay_slot ? LEARN_TARGET : e.vaddr + 32'd4;
		in_delay_slot = 1'b0;
	end
	fault_pops += int'(e.addr_ex);
	popped++;
endtask

// one clock: retire what decode acked, then drive the next cycle
task automatic step();
	int avail;
	@(posedge clk);
	for (int i = 0; i < ack_cur; i++) begin
		assert (fetch_valid[i]) else mismatch($sformatf("slot %0d acked but not valid", i));
		check_pop(fetch_entry[i]);
	end
	avail = flushing ? 0 : $countones(fetch_valid) - ack_cur;
	flushing = 1'b0;
	ack_cur = shake ? int'($urandom_range(avail, 0)) : avail;
	fetch_ack <= NW'(ack_cur);
	stall <= shake ? ($urandom_range(3, 0) == 0) : 1'b0;
	except_valid <= 1'b0;
	flush_pc <= 1'b0;
	resolved_branch <= '0;
endtask

// queue is flushed at the next edge, so nothing is acked
task automatic restart(input virt_t vec);
	fetch_ack <= '0;
	ack_cur = 0;
	flushing = 1'b1;
	in_delay_slot = 1'b0;
	exp_pc = vec;
endtask

task automatic redirect_to(input virt_t vec, input logic with_flush);
	except_valid <= 1'b1;
	flush_pc <= with_flush;
	except_vec <= vec;
	restart(vec);
endtask

task automatic mispredict(input virt_t at, input logic taken, input virt_t target);
	resolved_branch <= '{valid: 1'b1, mispredict: 1'b1, taken: taken, pc: at,
		target: target, cf: cf_branch};
	restart(taken ? target : at + 32'd8);
endtask

task automatic train_branch();
	resolved_branch <= '{valid: 1'b1, mispredict: 1'b0, taken: 1'b1, pc: LEARN_PC,
		target: LEARN_TARGET, cf: cf_branch};
	learned = 1'b1;
endtask

task automatic drain(input int n, input int limit);
	int goal;
	int cycles;
	goal = popped + n;
	cycles = 0;
	while (popped < goal) begin
		step();
		cycles++;
		if (cycles > limit) begin
			stop_on_error($sformatf("timeout: %0d entries not popped within %0d cycles",
				n, limit));
		end
	end
endtask

initial begin
	void'($urandom(98));
	rst_n = 1'b0;
	flush_pc = 1'b0;
	flush_bp = 1'b0;
	stall = 1'b0;
	except_valid = 1'b0;
	except_vec = '0;
	resolved_branch = '0;
	fetch_ack = '0;
	exp_pc = `BOOT_VEC;
	repeat (10) @(posedge clk);
	rst_n <= 1'b1;
	step();
	assert (fetch_valid == '0 && !icache_flush) else mismatch("outputs active after reset");
	assert (icache_vaddr == `BOOT_VEC)
		else mismatch($sformatf("first request %h, expected boot vector", icache_vaddr));

	// sequential fetch, then random ack and stall
	drain(16, 100);
	shake = 1'b1;
	drain(40, 400);

	step();
	redirect_to(`BOOT_VEC + 32'h0404, 1'b1);
	drain(8, 200);

	step();
	mispredict(`BOOT_VEC + 32'h0800, 1'b1, `BOOT_VEC + 32'h1000);
	drain(6, 200);
	step();
	mispredict(`BOOT_VEC + 32'h1800, 1'b0, '0);
	drain(6, 200);

	// two taken outcomes, then run through the branch
	step();
	train_branch();
	step();
	train_branch();
	step();
	redirect_to(LEARN_PC - 32'd4, 1'b1);
	drain(8, 200);
	assert (branch_pops == 1) else mismatch("learned branch was not popped once");

	// exception alone, without flush_pc
	step();
	redirect_to(`IMEM_LIMIT + 32'h8, 1'b0);
	drain(6, 200);
	assert (fault_pops >= 6) else mismatch("entries above the limit lack addr_ex");

	$display("PASS: all tests");
	$finish;
end

endmodule
